//--- axil_slave.sv
//----------------------------------------------------------
// AXI4-Lite slave that turns bus transfers into one-cycle
// register write and read strobes, one transfer at a time
//----------------------------------------------------------
`timescale 1ns/1ps

module axil_slave (
   input  logic                     clk,
   input  logic                     i_rst,
   // Write address and data
   input  bus_ctrl_pkg::axil_addr_t i_awaddr,
   input  logic                     i_awvalid,
   output logic                     o_awready,
   input  bus_ctrl_pkg::axil_data_t i_wdata,
   input  logic                     i_wvalid,
   output logic                     o_wready,
   // Write response
   output bus_ctrl_pkg::axil_resp_t o_bresp,
   output logic                     o_bvalid,
   input  logic                     i_bready,
   // Read address and data
   input  bus_ctrl_pkg::axil_addr_t i_araddr,
   input  logic                     i_arvalid,
   output logic                     o_arready,
   output bus_ctrl_pkg::axil_data_t o_rdata,
   output bus_ctrl_pkg::axil_resp_t o_rresp,
   output logic                     o_rvalid,
   input  logic                     i_rready,
   // Register strobes
   output logic                     o_wr_stb,
   output bus_ctrl_pkg::axil_addr_t o_wr_addr,
   output bus_ctrl_pkg::axil_data_t o_wr_data,
   output logic                     o_rd_stb,
   output bus_ctrl_pkg::axil_addr_t o_rd_addr,
   input  bus_ctrl_pkg::axil_data_t i_rd_data
);

   bus_ctrl_pkg::axil_state_t state;
   logic                      wr_ready;
   logic                      rd_ready;
   logic                      bvalid;
   logic                      rvalid;
   bus_ctrl_pkg::axil_data_t  rdata;

   // Transfer completes on the cycle the registered ready is high
   assign o_wr_stb  = wr_ready && i_awvalid && i_wvalid;
   assign o_wr_addr = i_awaddr;
   assign o_wr_data = i_wdata;
   assign o_rd_stb  = rd_ready && i_arvalid;
   assign o_rd_addr = i_araddr;

   assign o_awready = wr_ready;
   assign o_wready  = wr_ready;
   assign o_arready = rd_ready;
   assign o_bvalid  = bvalid;
   assign o_rvalid  = rvalid;
   assign o_rdata   = rdata;
   // Every access is OKAY, mapped or not
   assign o_bresp   = '0;
   assign o_rresp   = '0;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state    <= bus_ctrl_pkg::S_IDLE;
         wr_ready <= 1'b0;
         rd_ready <= 1'b0;
         bvalid   <= 1'b0;
         rvalid   <= 1'b0;
      end else begin
         case (state)
            bus_ctrl_pkg::S_IDLE: begin
               if (o_wr_stb) begin
                  wr_ready <= 1'b0;
                  bvalid   <= 1'b1;
                  state    <= bus_ctrl_pkg::S_WRITE_RESP;
               end else if (o_rd_stb) begin
                  rd_ready <= 1'b0;
                  rvalid   <= 1'b1;
                  state    <= bus_ctrl_pkg::S_READ_DATA;
               end else if (!wr_ready && !rd_ready) begin
                  // Write wins when both are pending
                  if (i_awvalid && i_wvalid) begin
                     wr_ready <= 1'b1;
                  end else if (i_arvalid) begin
                     rd_ready <= 1'b1;
                  end
               end
            end
            bus_ctrl_pkg::S_WRITE_RESP: begin
               if (i_bready) begin
                  bvalid <= 1'b0;
                  state  <= bus_ctrl_pkg::S_IDLE;
               end
            end
            bus_ctrl_pkg::S_READ_DATA: begin
               if (i_rready) begin
                  rvalid <= 1'b0;
                  state  <= bus_ctrl_pkg::S_IDLE;
               end
            end
            default: state <= bus_ctrl_pkg::S_IDLE;
         endcase
      end
   end

   // Readback word held until RREADY
   always_ff @(posedge clk) begin
      if (o_rd_stb) begin
         rdata <= i_rd_data;
      end
   end

   a_one_response: assert property (@(posedge clk) disable iff (i_rst)
      !(bvalid && rvalid));

endmodule

//--- bus_ctrl_macros.svh
//----------------------------------------------------------
// Address map, reset values and field widths of the board
// control block. Include wherever a register offset is used.
//----------------------------------------------------------
`ifndef BUS_CTRL_MACROS_SVH
`define BUS_CTRL_MACROS_SVH

// Bus widths
`define BUS_CTRL_AXIL_AW          12
`define BUS_CTRL_DATA_W           32

// Field widths
`define BUS_CTRL_LED_W            8
`define BUS_CTRL_SW_RST_W         4
`define BUS_CTRL_CLOCK_W          8
`define BUS_CTRL_SFPP_CTRL_W      2
`define BUS_CTRL_SFPP_PINS_W      3

// Setting register offsets
`define BUS_CTRL_SR_LEDS          12'h000
`define BUS_CTRL_SR_SW_RST        12'h004
`define BUS_CTRL_SR_CLOCK_CTRL    12'h008
`define BUS_CTRL_SR_SFPP_CTRL0    12'h020
`define BUS_CTRL_SR_SFPP_CTRL1    12'h024

// Readback offsets
`define BUS_CTRL_RB_COUNTER       12'h100
`define BUS_CTRL_RB_CLK_STATUS    12'h10C
`define BUS_CTRL_RB_COMPAT        12'h118
`define BUS_CTRL_RB_SFPP_STATUS0  12'h120
`define BUS_CTRL_RB_SFPP_STATUS1  12'h124

// Compatibility number and reset values
`define BUS_CTRL_COMPAT_MAJOR     16'd1000
`define BUS_CTRL_COMPAT_MINOR     16'd0
`define BUS_CTRL_CLOCK_CTRL_RST   8'h40

`endif

//--- bus_ctrl_pkg.sv
//----------------------------------------------------------
// Shared types of the board control block, taken by scoped
// names from every module of the design
//----------------------------------------------------------
`include "bus_ctrl_macros.svh"

package bus_ctrl_pkg;

   // AXI4-Lite bus
   typedef logic [`BUS_CTRL_AXIL_AW-1:0] axil_addr_t;
   typedef logic [`BUS_CTRL_DATA_W-1:0]  axil_data_t;
   typedef logic [1:0]                   axil_resp_t;

   // Board settings
   typedef logic [`BUS_CTRL_LED_W-1:0]    led_t;
   // [0] PHY, [1] radio domain, [2] radio PLL, [3] ADC delay control
   typedef logic [`BUS_CTRL_SW_RST_W-1:0] sw_rst_t;
   typedef logic [`BUS_CTRL_CLOCK_W-1:0]  clock_ctrl_t;
   typedef logic [`BUS_CTRL_CLOCK_W-1:0]  clock_status_t;

   // SFP+ cage
   // RS0 in bit 0, RS1 in bit 1; a set bit pulls the pin low
   typedef logic [`BUS_CTRL_SFPP_CTRL_W-1:0]   sfpp_ctrl_t;
   // {mod_abs, tx_fault, rx_los}
   typedef logic [`BUS_CTRL_SFPP_PINS_W-1:0]   sfpp_pins_t;
   // {changed flags, synchronized pins}
   typedef logic [2*`BUS_CTRL_SFPP_PINS_W-1:0] sfpp_status_t;

   // Slave FSM
   typedef enum logic [1:0] {
      S_IDLE,
      S_WRITE_RESP,
      S_READ_DATA
   } axil_state_t;

endpackage

//--- bus_ctrl_top.sv
//----------------------------------------------------------
// Board control block top. AXI4-Lite register access to the
// board settings and to the status of both SFP+ cages
//----------------------------------------------------------
`timescale 1ns/1ps

module bus_ctrl_top (
   input  logic                        clk,
   input  logic                        i_rst,
   // AXI4-Lite slave
   input  bus_ctrl_pkg::axil_addr_t    i_awaddr,
   input  logic                        i_awvalid,
   output logic                        o_awready,
   input  bus_ctrl_pkg::axil_data_t    i_wdata,
   input  logic                        i_wvalid,
   output logic                        o_wready,
   output bus_ctrl_pkg::axil_resp_t    o_bresp,
   output logic                        o_bvalid,
   input  logic                        i_bready,
   input  bus_ctrl_pkg::axil_addr_t    i_araddr,
   input  logic                        i_arvalid,
   output logic                        o_arready,
   output bus_ctrl_pkg::axil_data_t    o_rdata,
   output bus_ctrl_pkg::axil_resp_t    o_rresp,
   output logic                        o_rvalid,
   input  logic                        i_rready,
   // Board pins
   input  bus_ctrl_pkg::clock_status_t i_clock_status,
   input  bus_ctrl_pkg::sfpp_pins_t    i_sfpp0_pins,
   input  bus_ctrl_pkg::sfpp_pins_t    i_sfpp1_pins,
   output bus_ctrl_pkg::led_t          o_leds,
   output bus_ctrl_pkg::sw_rst_t       o_sw_rst,
   output bus_ctrl_pkg::clock_ctrl_t   o_clock_control,
   // Open-drain RS pins leave as drive-low enables
   output bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp0_rs_oe,
   output bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp1_rs_oe
);

   logic                       wr_stb;
   bus_ctrl_pkg::axil_addr_t   wr_addr;
   bus_ctrl_pkg::axil_data_t   wr_data;
   logic                       rd_stb;
   bus_ctrl_pkg::axil_addr_t   rd_addr;
   bus_ctrl_pkg::axil_data_t   rd_data;
   bus_ctrl_pkg::sfpp_status_t sfpp0_status;
   bus_ctrl_pkg::sfpp_status_t sfpp1_status;
   logic                       sfpp0_clr;
   logic                       sfpp1_clr;

   axil_slave u_axil_slave (
      .clk(clk), .i_rst(i_rst),
      .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
      .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
      .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
      .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
      .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
      .o_wr_stb(wr_stb), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
      .o_rd_stb(rd_stb), .o_rd_addr(rd_addr), .i_rd_data(rd_data)
   );

   ctrl_regs u_ctrl_regs (
      .clk(clk), .i_rst(i_rst),
      .i_wr_stb(wr_stb), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
      .i_rd_stb(rd_stb), .i_rd_addr(rd_addr), .o_rd_data(rd_data),
      .i_clock_status(i_clock_status),
      .i_sfpp0_status(sfpp0_status), .i_sfpp1_status(sfpp1_status),
      .o_sfpp0_clr(sfpp0_clr), .o_sfpp1_clr(sfpp1_clr),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control),
      .o_sfpp0_rs_oe(o_sfpp0_rs_oe), .o_sfpp1_rs_oe(o_sfpp1_rs_oe)
   );

   // Cage 0
   sfpp_status_mon u_sfpp0_mon (
      .clk(clk), .i_rst(i_rst),
      .i_pins(i_sfpp0_pins), .i_clr(sfpp0_clr), .o_status(sfpp0_status)
   );

   // Cage 1
   sfpp_status_mon u_sfpp1_mon (
      .clk(clk), .i_rst(i_rst),
      .i_pins(i_sfpp1_pins), .i_clr(sfpp1_clr), .o_status(sfpp1_status)
   );

endmodule

//--- bus_ctrl_vectors.txt
// op addr value: 1 write, 2 read and compare, 3 set SFP pins of cage addr, 4 set clock status
// 5 check output addr (0 leds, 1 sw_rst, 2 clock ctrl, 3 rs_oe0, 4 rs_oe1), 6 counter rise, 0 end
5 000 00000000
5 001 00000000
5 002 00000040
5 003 00000000
5 004 00000000
1 000 123456a5
5 000 000000a5
1 004 fffffffb
5 001 0000000b
1 008 00000081
5 002 00000081
1 020 00000002
5 003 00000002
1 024 00000007
5 004 00000003
1 0fc 000000ff
5 000 000000a5
5 002 00000081
2 118 03e80000
4 000 0000005a
2 10c 0000005a
2 200 00000000
2 000 00000000
3 000 00000005
2 120 0000002d
2 120 00000005
2 124 00000000
3 001 00000002
2 124 00000012
2 124 00000002
2 120 00000005
3 000 00000000
2 120 00000028
2 120 00000000
6 100 00000000
0 000 00000000

//--- ctrl_regs.sv
//----------------------------------------------------------
// Board setting registers and readback mux, fed by the
// write and read strobes of the AXI4-Lite slave
//----------------------------------------------------------
`timescale 1ns/1ps
`include "bus_ctrl_macros.svh"

module ctrl_regs (
   input  logic                        clk,
   input  logic                        i_rst,
   // Register strobes
   input  logic                        i_wr_stb,
   input  bus_ctrl_pkg::axil_addr_t    i_wr_addr,
   input  bus_ctrl_pkg::axil_data_t    i_wr_data,
   input  logic                        i_rd_stb,
   input  bus_ctrl_pkg::axil_addr_t    i_rd_addr,
   output bus_ctrl_pkg::axil_data_t    o_rd_data,
   // Status inputs
   input  bus_ctrl_pkg::clock_status_t i_clock_status,
   input  bus_ctrl_pkg::sfpp_status_t  i_sfpp0_status,
   input  bus_ctrl_pkg::sfpp_status_t  i_sfpp1_status,
   output logic                        o_sfpp0_clr,
   output logic                        o_sfpp1_clr,
   // Settings
   output bus_ctrl_pkg::led_t          o_leds,
   output bus_ctrl_pkg::sw_rst_t       o_sw_rst,
   output bus_ctrl_pkg::clock_ctrl_t   o_clock_control,
   output bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp0_rs_oe,
   output bus_ctrl_pkg::sfpp_ctrl_t    o_sfpp1_rs_oe
);

   bus_ctrl_pkg::axil_data_t counter;

   //----------------------------------------------------------
   // Setting registers
   //----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         // GPS oscillator on by default
         o_clock_control <= `BUS_CTRL_CLOCK_CTRL_RST;
         o_sfpp0_rs_oe   <= '0;
         o_sfpp1_rs_oe   <= '0;
      end else if (i_wr_stb) begin
         case (i_wr_addr)
            `BUS_CTRL_SR_LEDS: begin
               o_leds <= i_wr_data[`BUS_CTRL_LED_W-1:0];
            end
            `BUS_CTRL_SR_SW_RST: begin
               o_sw_rst <= i_wr_data[`BUS_CTRL_SW_RST_W-1:0];
            end
            `BUS_CTRL_SR_CLOCK_CTRL: begin
               o_clock_control <= i_wr_data[`BUS_CTRL_CLOCK_W-1:0];
            end
            `BUS_CTRL_SR_SFPP_CTRL0: begin
               o_sfpp0_rs_oe <= i_wr_data[`BUS_CTRL_SFPP_CTRL_W-1:0];
            end
            `BUS_CTRL_SR_SFPP_CTRL1: begin
               o_sfpp1_rs_oe <= i_wr_data[`BUS_CTRL_SFPP_CTRL_W-1:0];
            end
            // Unmapped offsets are dropped
            default: ;
         endcase
      end
   end

   // Free-running cycle counter
   always_ff @(posedge clk) begin
      if (i_rst) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   //----------------------------------------------------------
   // Readback
   //----------------------------------------------------------
   always_comb begin
      o_rd_data = '0;
      case (i_rd_addr)
         `BUS_CTRL_RB_COUNTER: begin
            o_rd_data = counter;
         end
         `BUS_CTRL_RB_CLK_STATUS: begin
            o_rd_data = bus_ctrl_pkg::axil_data_t'(i_clock_status);
         end
         `BUS_CTRL_RB_COMPAT: begin
            o_rd_data = {`BUS_CTRL_COMPAT_MAJOR, `BUS_CTRL_COMPAT_MINOR};
         end
         `BUS_CTRL_RB_SFPP_STATUS0: begin
            o_rd_data = bus_ctrl_pkg::axil_data_t'(i_sfpp0_status);
         end
         `BUS_CTRL_RB_SFPP_STATUS1: begin
            o_rd_data = bus_ctrl_pkg::axil_data_t'(i_sfpp1_status);
         end
         default: ;
      endcase
   end

   // Reading a status word clears its change flags at the capture edge
   assign o_sfpp0_clr = i_rd_stb && (i_rd_addr == `BUS_CTRL_RB_SFPP_STATUS0);
   assign o_sfpp1_clr = i_rd_stb && (i_rd_addr == `BUS_CTRL_RB_SFPP_STATUS1);

   a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (i_rst)
      !(i_wr_stb && i_rd_stb));

endmodule

//--- sfpp_status_mon.sv
//----------------------------------------------------------
// Status monitor for one SFP+ cage. Synchronizes the status
// pins and latches any edge until the word is read back
//----------------------------------------------------------
`timescale 1ns/1ps

module sfpp_status_mon (
   input  logic                       clk,
   input  logic                       i_rst,
   input  bus_ctrl_pkg::sfpp_pins_t   i_pins,
   input  logic                       i_clr,
   output bus_ctrl_pkg::sfpp_status_t o_status
);

   bus_ctrl_pkg::sfpp_pins_t meta;
   bus_ctrl_pkg::sfpp_pins_t sync;
   bus_ctrl_pkg::sfpp_pins_t sync_dly;
   bus_ctrl_pkg::sfpp_pins_t chgd;

   // Two-flop synchronizer and one more stage for edge detect
   always_ff @(posedge clk) begin
      if (i_rst) begin
         meta     <= '0;
         sync     <= '0;
         sync_dly <= '0;
      end else begin
         meta     <= i_pins;
         sync     <= meta;
         sync_dly <= sync;
      end
   end

   // Sticky change flags
   // Clear has priority over a new edge
   always_ff @(posedge clk) begin
      if (i_rst || i_clr) begin
         chgd <= '0;
      end else begin
         chgd <= chgd | (sync ^ sync_dly);
      end
   end

   assign o_status = {chgd, sync};

   // Clear comes from the read decode as a single-cycle pulse
   a_clr_pulse: assert property (@(posedge clk) disable iff (i_rst)
      i_clr |=> !i_clr);

endmodule

//--- src.f
+incdir+.
bus_ctrl_pkg.sv
axil_slave.sv
ctrl_regs.sv
sfpp_status_mon.sv
bus_ctrl_top.sv
tb_bus_ctrl.sv

//--- tb_bus_ctrl.sv
//----------------------------------------------------------
// Self-checking testbench of the board control block. Runs
// the operations of bus_ctrl_vectors.txt through the bus
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_bus_ctrl;

   localparam int TIMEOUT  = 200;
   localparam int MAX_VECS = 64;

   logic                        clk;
   logic                        i_rst;
   bus_ctrl_pkg::axil_addr_t    awaddr;
   logic                        awvalid;
   logic                        awready;
   bus_ctrl_pkg::axil_data_t    wdata;
   logic                        wvalid;
   logic                        wready;
   bus_ctrl_pkg::axil_resp_t    bresp;
   logic                        bvalid;
   logic                        bready;
   bus_ctrl_pkg::axil_addr_t    araddr;
   logic                        arvalid;
   logic                        arready;
   bus_ctrl_pkg::axil_data_t    rdata;
   bus_ctrl_pkg::axil_resp_t    rresp;
   logic                        rvalid;
   logic                        rready;
   bus_ctrl_pkg::clock_status_t clock_status;
   bus_ctrl_pkg::sfpp_pins_t    sfpp0_pins;
   bus_ctrl_pkg::sfpp_pins_t    sfpp1_pins;
   bus_ctrl_pkg::led_t          leds;
   bus_ctrl_pkg::sw_rst_t       sw_rst;
   bus_ctrl_pkg::clock_ctrl_t   clock_control;
   bus_ctrl_pkg::sfpp_ctrl_t    sfpp0_rs_oe;
   bus_ctrl_pkg::sfpp_ctrl_t    sfpp1_rs_oe;

   // Three words per operation: op, address or selector, value
   logic [31:0] vec_mem [0:3*MAX_VECS-1];
   integer      seed;

   bus_ctrl_top DUT (
      .clk(clk), .i_rst(i_rst),
      .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
      .i_wdata(wdata), .i_wvalid(wvalid), .o_wready(wready),
      .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
      .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
      .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
      .i_clock_status(clock_status),
      .i_sfpp0_pins(sfpp0_pins), .i_sfpp1_pins(sfpp1_pins),
      .o_leds(leds), .o_sw_rst(sw_rst), .o_clock_control(clock_control),
      .o_sfpp0_rs_oe(sfpp0_rs_oe), .o_sfpp1_rs_oe(sfpp1_rs_oe)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped");
   endtask

   //----------------------------------------------------------
   // Compare tasks
   //----------------------------------------------------------
   task automatic check_data(input string name, input bus_ctrl_pkg::axil_data_t exp,
                             input bus_ctrl_pkg::axil_data_t act);
      if (act !== exp) begin
         fail_run($sformatf("Mismatch %s expected 0x%08h actual 0x%08h", name, exp, act));
      end
   endtask

   task automatic check_increasing(input string name, input bus_ctrl_pkg::axil_data_t prev,
                                   input bus_ctrl_pkg::axil_data_t act);
      if (!(act > prev)) begin
         fail_run($sformatf("Mismatch %s expected above 0x%08h actual 0x%08h",
                            name, prev, act));
      end
   endtask

   task automatic check_resp(input string name, input bus_ctrl_pkg::axil_resp_t exp,
                             input bus_ctrl_pkg::axil_resp_t act);
      if (act !== exp) begin
         fail_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   task automatic check_leds(input string name, input bus_ctrl_pkg::led_t exp,
                             input bus_ctrl_pkg::led_t act);
      if (act !== exp) begin
         fail_run($sformatf("Mismatch %s expected 0x%02h actual 0x%02h", name, exp, act));
      end
   endtask

   task automatic check_sw_rst(input string name, input bus_ctrl_pkg::sw_rst_t exp,
                               input bus_ctrl_pkg::sw_rst_t act);
      if (act !== exp) begin
         fail_run($sformatf("Mismatch %s expected 0x%01h actual 0x%01h", name, exp, act));
      end
   endtask

   task automatic check_clock_ctrl(input string name, input bus_ctrl_pkg::clock_ctrl_t exp,
                                   input bus_ctrl_pkg::clock_ctrl_t act);
      if (act !== exp) begin
         fail_run($sformatf("Mismatch %s expected 0x%02h actual 0x%02h", name, exp, act));
      end
   endtask

   task automatic check_rs_oe(input string name, input bus_ctrl_pkg::sfpp_ctrl_t exp,
                              input bus_ctrl_pkg::sfpp_ctrl_t act);
      if (act !== exp) begin
         fail_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   //----------------------------------------------------------
   // Bus transfers
   //----------------------------------------------------------
   // One sample per falling edge, bounded by TIMEOUT
   task automatic tick_or_timeout(inout int count, input string what);
      @(negedge clk);
      count++;
      if (count > TIMEOUT) begin
         fail_run($sformatf("Timeout while waiting for %s", what));
      end
   endtask

   task automatic axil_write(input bus_ctrl_pkg::axil_addr_t addr,
                             input bus_ctrl_pkg::axil_data_t data, input string name);
      int count;
      int delay;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      count = 0;
      tick_or_timeout(count, "AWREADY and WREADY");
      while (!(awready && wready)) begin
         tick_or_timeout(count, "AWREADY and WREADY");
      end
      // Transfer edge
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      count = 0;
      tick_or_timeout(count, "BVALID");
      while (!bvalid) begin
         tick_or_timeout(count, "BVALID");
      end
      check_resp({name, " bresp"}, 2'b00, bresp);
      delay = $random(seed) & 3;
      repeat (delay) begin
         @(negedge clk);
         if (!bvalid) begin
            fail_run("BVALID dropped before BREADY was given");
         end
      end
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
      @(negedge clk);
      if (bvalid) begin
         fail_run("BVALID still high after the write response handshake");
      end
   endtask

   task automatic axil_read(input bus_ctrl_pkg::axil_addr_t addr,
                            output bus_ctrl_pkg::axil_data_t data, input string name);
      int count;
      int delay;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      count = 0;
      tick_or_timeout(count, "ARREADY");
      while (!arready) begin
         tick_or_timeout(count, "ARREADY");
      end
      @(posedge clk);
      arvalid <= 1'b0;
      count = 0;
      tick_or_timeout(count, "RVALID");
      while (!rvalid) begin
         tick_or_timeout(count, "RVALID");
      end
      check_resp({name, " rresp"}, 2'b00, rresp);
      data = rdata;
      delay = $random(seed) & 3;
      repeat (delay) begin
         @(negedge clk);
         if (!rvalid) begin
            fail_run("RVALID dropped before RREADY was given");
         end
         check_data({name, " rdata held"}, data, rdata);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
      @(negedge clk);
      if (rvalid) begin
         fail_run("RVALID still high after the read data handshake");
      end
   endtask

   //----------------------------------------------------------
   // Vector run
   //----------------------------------------------------------
   initial begin
      int                       idx;
      bit                       done;
      logic [31:0]              op;
      bus_ctrl_pkg::axil_addr_t addr;
      logic [31:0]              value;
      bus_ctrl_pkg::axil_data_t got;
      bus_ctrl_pkg::axil_data_t first;
      string                    name;

      seed         = 32'h2de3_8814;
      i_rst        = 1'b1;
      awaddr       = '0;
      awvalid      = 1'b0;
      wdata        = '0;
      wvalid       = 1'b0;
      bready       = 1'b0;
      araddr       = '0;
      arvalid      = 1'b0;
      rready       = 1'b0;
      clock_status = '0;
      sfpp0_pins   = '0;
      sfpp1_pins   = '0;
      $readmemh("bus_ctrl_vectors.txt", vec_mem);

      repeat (16) @(posedge clk);
      i_rst <= 1'b0;

      idx  = 0;
      done = 1'b0;
      while (!done) begin
         if (idx >= MAX_VECS) begin
            fail_run("Vector file has no end operation");
         end
         op    = vec_mem[3*idx];
         addr  = vec_mem[3*idx+1][11:0];
         value = vec_mem[3*idx+2];
         name  = $sformatf("vector %0d op %0d at 0x%03h", idx, op, addr);
         if ($isunknown(op)) begin
            fail_run("Vector file is missing or incomplete");
         end
         case (op)
            0: done = 1'b1;
            1: axil_write(addr, value, name);
            2: begin
               axil_read(addr, got, name);
               check_data(name, value, got);
            end
            3: begin
               @(posedge clk);
               if (addr == 0) begin
                  sfpp0_pins <= value[2:0];
               end else begin
                  sfpp1_pins <= value[2:0];
               end
               // Synchronizer plus edge detect settle
               repeat (4) @(posedge clk);
            end
            4: begin
               @(posedge clk);
               clock_status <= value[7:0];
            end
            5: begin
               @(negedge clk);
               case (addr)
                  0: check_leds(name, value[7:0], leds);
                  1: check_sw_rst(name, value[3:0], sw_rst);
                  2: check_clock_ctrl(name, value[7:0], clock_control);
                  3: check_rs_oe(name, value[1:0], sfpp0_rs_oe);
                  4: check_rs_oe(name, value[1:0], sfpp1_rs_oe);
                  default: fail_run($sformatf("Unknown output selector in %s", name));
               endcase
            end
            6: begin
               axil_read(addr, first, name);
               axil_read(addr, got, name);
               check_increasing(name, first, got);
            end
            default: fail_run($sformatf("Unknown operation code in %s", name));
         endcase
         idx++;
      end

      $display("*** PASSED ***");
      $finish;
   end

endmodule
